// File: rtl/line_buf_cfg.svh
`ifndef LINE_BUF_CFG_SVH
`define LINE_BUF_CFG_SVH

// pixel format
`define LB_PIX_W 24 // rgb, 8 bits per channel

// source image size
`define LB_IMG_W 16
`define LB_IMG_H 8

// bicubic window side, rows and columns alike
`define LB_WIN 4

// line rams in rotation
// four are read while the fifth takes the next row
`define LB_SLOTS 5

`endif

// File: rtl/line_buf_pkg.sv
`default_nettype none

`include "line_buf_cfg.svh"

package line_buf_pkg;

    typedef logic [`LB_PIX_W-1:0]            pixel_t;
    typedef logic [$clog2(`LB_IMG_W)-1:0]    col_addr_t;
    typedef logic [$clog2(`LB_SLOTS)-1:0]    slot_t;
    typedef logic [$clog2(`LB_IMG_H+1)-1:0]  row_cnt_t;  // reaches IMG_H at frame end

    // one write into the bank
    typedef struct packed {
        logic      en;
        slot_t     slot;
        col_addr_t addr;
        pixel_t    data;
    } ram_wr_t;

    // one column read, every lane uses the same address
    typedef struct packed {
        logic                en;
        col_addr_t           addr;
        slot_t [`LB_WIN-1:0] lane_slot;  // lane 0 is the top window row
    } ram_rd_t;

    // one pixel per window row, lane 0 on top
    typedef pixel_t [`LB_WIN-1:0] ram_col_t;

    // [row][col], row 0 on top and col 0 leftmost
    typedef pixel_t [`LB_WIN-1:0][`LB_WIN-1:0] window_t;

endpackage

`default_nettype wire

// File: rtl/pixel_writer.sv
`default_nettype none

`include "line_buf_cfg.svh"

module pixel_writer (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    input  wire logic                   pix_valid,
    input  wire line_buf_pkg::pixel_t   pix_data,
    output logic                        pix_ready,

    output line_buf_pkg::ram_wr_t       ram_wr,
    output line_buf_pkg::row_cnt_t      rows_written,

    input  wire line_buf_pkg::row_cnt_t rows_done,
    input  wire logic                   frame_done
);
    import line_buf_pkg::*;

    col_addr_t col_cnt;   // next column to write
    slot_t     slot_cnt;  // ram taking the current row
    logic      pix_hsk;
    logic      row_end;

    // one slot always stays with the reader, so the writer runs
    // at most LB_SLOTS-1 rows ahead of the rows already consumed
    assign pix_ready = (int'(rows_written) < `LB_IMG_H) &&
                       (int'(rows_written) < int'(rows_done) + (`LB_SLOTS - 1));

    assign pix_hsk = pix_valid && pix_ready;
    assign row_end = (col_cnt == col_addr_t'(`LB_IMG_W - 1));

    // write goes out in the same cycle as the transfer
    always_comb begin
        ram_wr.en   = pix_hsk;
        ram_wr.slot = slot_cnt;
        ram_wr.addr = col_cnt;
        ram_wr.data = pix_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_cnt      <= '0;
            slot_cnt     <= '0;
            rows_written <= '0;
        end else if (frame_done) begin
            // next frame starts again at row 0 in slot 0
            col_cnt      <= '0;
            slot_cnt     <= '0;
            rows_written <= '0;
        end else if (pix_hsk) begin
            if (row_end) begin
                col_cnt      <= '0;
                rows_written <= rows_written + 1'b1;
                if (slot_cnt == slot_t'(`LB_SLOTS - 1)) begin
                    slot_cnt <= '0;
                end else begin
                    slot_cnt <= slot_cnt + 1'b1;
                end
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/line_ram_bank.sv
`default_nettype none

`include "line_buf_cfg.svh"

module line_ram_bank (
    input  wire logic                  clk,

    input  wire line_buf_pkg::ram_wr_t ram_wr,
    input  wire line_buf_pkg::ram_rd_t ram_rd,
    output line_buf_pkg::ram_col_t     ram_col
);
    import line_buf_pkg::*;

    pixel_t              rd_word [`LB_SLOTS];  // registered read port of each ram
    slot_t [`LB_WIN-1:0] lane_q;               // lane selects aligned with rd_word

    // one single-port style line ram per slot
    // write and read both sync, the reader never reads the slot being written
    for (genvar s = 0; s < `LB_SLOTS; s++) begin : g_ram
        pixel_t mem [`LB_IMG_W];

        always_ff @(posedge clk) begin
            if (ram_wr.en && (ram_wr.slot == slot_t'(s))) begin
                mem[ram_wr.addr] <= ram_wr.data;
            end
            if (ram_rd.en) begin
                rd_word[s] <= mem[ram_rd.addr];
            end
        end
    end

    // slot choice per lane travels with the read
    always_ff @(posedge clk) begin
        if (ram_rd.en) begin
            lane_q <= ram_rd.lane_slot;
        end
    end

    // clamped edge rows select the same slot on more than one lane
    always_comb begin
        for (int l = 0; l < `LB_WIN; l++) begin
            ram_col[l] = rd_word[lane_q[l]];
        end
    end

endmodule

`default_nettype wire

// File: rtl/window_reader.sv
`default_nettype none

`include "line_buf_cfg.svh"

module window_reader (
    input  wire logic                    clk,
    input  wire logic                    rst_n,

    input  wire line_buf_pkg::row_cnt_t  rows_written,

    output line_buf_pkg::ram_rd_t        ram_rd,
    input  wire line_buf_pkg::ram_col_t  ram_col,

    output line_buf_pkg::row_cnt_t       rows_done,
    output logic                         frame_done,

    output logic                         win_valid,
    output line_buf_pkg::window_t        win_data,
    input  wire logic                    win_ready
);
    import line_buf_pkg::*;

    localparam int FETCH_W = $clog2(`LB_IMG_W + 1);  // also holds IMG_W, all fetched

    row_cnt_t            out_row;     // output row k
    logic [FETCH_W-1:0]  fetch_col;   // next column to fetch in this row
    logic                fetch_pend;  // read data shows up this cycle
    slot_t [`LB_WIN-1:0] src_slot;
    logic                row_ready;
    logic                fetch;
    logic                win_acc;
    logic                row_last;

    // replicate the top and bottom rows at the frame edges
    function automatic int clamp_row(input int r);
        int c;
        c = r;
        if (r < 0) begin
            c = 0;
        end else if (r > `LB_IMG_H - 1) begin
            c = `LB_IMG_H - 1;
        end
        return c;
    endfunction

    // window rows are k-1 .. k+2, row r lives in slot r mod LB_SLOTS
    always_comb begin
        for (int i = 0; i < `LB_WIN; i++) begin
            src_slot[i] = slot_t'(clamp_row(int'(out_row) - 1 + i) % `LB_SLOTS);
        end
    end

    // the lowest window row has to be complete in its ram
    assign row_ready = (int'(out_row) < `LB_IMG_H) &&
                       (int'(rows_written) > clamp_row(int'(out_row) + `LB_WIN - 2));

    assign win_acc  = win_valid && win_ready;
    assign row_last = win_acc && (fetch_col == FETCH_W'(`LB_IMG_W));

    // one read in flight at a time
    // a fetch goes out only when the window is empty or leaves this cycle,
    // so it never lands on a window still waiting for win_ready
    assign fetch = row_ready &&
                   (fetch_col < FETCH_W'(`LB_IMG_W)) &&
                   !fetch_pend &&
                   (!win_valid || win_ready);

    always_comb begin
        ram_rd.en        = fetch;
        ram_rd.addr      = col_addr_t'(fetch_col);
        ram_rd.lane_slot = src_slot;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_row    <= '0;
            fetch_col  <= '0;
            fetch_pend <= 1'b0;
            win_valid  <= 1'b0;
        end else begin
            fetch_pend <= fetch;

            if (frame_done) begin
                out_row <= '0;
            end else if (row_last) begin
                out_row <= out_row + 1'b1;
            end

            if (row_last) begin
                fetch_col <= '0;
            end else if (fetch) begin
                fetch_col <= fetch_col + 1'b1;
            end

            // fetch_col is one past the column shifting in
            if (fetch_pend && (fetch_col >= FETCH_W'(`LB_WIN))) begin
                win_valid <= 1'b1;  // four columns of this row are in
            end else if (win_acc) begin
                win_valid <= 1'b0;
            end
        end
    end

    // new column enters on the right, oldest drops off the left
    always_ff @(posedge clk) begin
        if (fetch_pend) begin
            for (int i = 0; i < `LB_WIN; i++) begin
                for (int j = 0; j < `LB_WIN - 1; j++) begin
                    win_data[i][j] <= win_data[i][j+1];
                end
                win_data[i][`LB_WIN-1] <= ram_col[i];
            end
        end
    end

    assign rows_done = out_row;

    // out_row sits at IMG_H for one cycle after the last window
    assign frame_done = (out_row == row_cnt_t'(`LB_IMG_H));

endmodule

`default_nettype wire

// File: rtl/line_buf_top.sv
`default_nettype none

module line_buf_top (
    input  wire logic                  clk,
    input  wire logic                  rst_n,

    // pixel stream in, raster order
    input  wire logic                  pix_valid,
    input  wire line_buf_pkg::pixel_t  pix_data,
    output wire logic                  pix_ready,

    // 4x4 window out to the interpolator
    output wire logic                  win_valid,
    output wire line_buf_pkg::window_t win_data,
    input  wire logic                  win_ready,

    output wire logic                  frame_done
);
    import line_buf_pkg::*;

    ram_wr_t  ram_wr;
    ram_rd_t  ram_rd;
    ram_col_t ram_col;
    row_cnt_t rows_written;
    row_cnt_t rows_done;

    pixel_writer u_writer (
        .clk          (clk),
        .rst_n        (rst_n),
        .pix_valid    (pix_valid),
        .pix_data     (pix_data),
        .pix_ready    (pix_ready),
        .ram_wr       (ram_wr),
        .rows_written (rows_written),
        .rows_done    (rows_done),
        .frame_done   (frame_done)
    );

    line_ram_bank u_bank (
        .clk     (clk),
        .ram_wr  (ram_wr),
        .ram_rd  (ram_rd),
        .ram_col (ram_col)
    );

    window_reader u_reader (
        .clk          (clk),
        .rst_n        (rst_n),
        .rows_written (rows_written),
        .ram_rd       (ram_rd),
        .ram_col      (ram_col),
        .rows_done    (rows_done),
        .frame_done   (frame_done),
        .win_valid    (win_valid),
        .win_data     (win_data),
        .win_ready    (win_ready)
    );

endmodule

`default_nettype wire

// File: testbench/line_buf_tb.sv
`default_nettype none

`include "line_buf_cfg.svh"

module line_buf_tb;
    import line_buf_pkg::*;

    localparam int PIX_N      = `LB_IMG_H * `LB_IMG_W;
    localparam int WIN_N      = `LB_IMG_H * (`LB_IMG_W - 3);
    localparam int WIN_BITS   = $bits(window_t);
    localparam int WAIT_LIMIT = 2000;  // cycles without progress
    localparam int N_TESTS    = 5;

    typedef struct packed {
        logic [7:0] valid_pct;
        logic [7:0] ready_pct;
        logic       coded;  // row/column coded pixels, else random
    } test_row_t;

    logic    clk;
    logic    rst_n;
    logic    pix_valid;
    pixel_t  pix_data;
    logic    pix_ready;
    logic    win_valid;
    window_t win_data;
    logic    win_ready;
    logic    frame_done;

    test_row_t tests [N_TESTS];
    pixel_t    img [`LB_IMG_H][`LB_IMG_W];
    window_t   exp_q [$];

    int      error_cnt   = 0;
    int      timeout_cnt = 0;
    int      win_checked = 0;
    int      frames_run  = 0;
    int      frame_no    = 0;
    logic    abort       = 1'b0;

    // monitor state
    logic    stall_q  = 1'b0;
    logic    done_q   = 1'b0;
    window_t held_data;
    int      pix_cnt  = 0;
    int      win_seen = 0;
    int      done_cnt = 0;

    line_buf_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .pix_valid  (pix_valid),
        .pix_data   (pix_data),
        .pix_ready  (pix_ready),
        .win_valid  (win_valid),
        .win_data   (win_data),
        .win_ready  (win_ready),
        .frame_done (frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_val(input logic [WIN_BITS-1:0] got, input logic [WIN_BITS-1:0] exp,
                             input string msg);
        if (got !== exp) begin
            $display("FAIL at %0t: %s (got %0h, expected %0h)", $time, msg, got, exp);
            error_cnt++;
        end
    endtask

    function automatic int clamp_index(input int r);
        int res;
        res = r;
        if (r < 0) begin
            res = 0;
        end else if (r >= `LB_IMG_H) begin
            res = `LB_IMG_H - 1;
        end
        return res;
    endfunction

    task automatic fill_image(input logic coded);
        for (int r = 0; r < `LB_IMG_H; r++) begin
            for (int c = 0; c < `LB_IMG_W; c++) begin
                if (coded) begin
                    img[r][c] = pixel_t'((frame_no % 256) * 65536 + r * 256 + c);
                end else begin
                    img[r][c] = pixel_t'($urandom);
                end
            end
        end
    endtask

    // windows in row-major order, edge rows replicated
    task automatic build_expected();
        window_t w;
        exp_q.delete();
        for (int k = 0; k < `LB_IMG_H; k++) begin
            for (int c = 0; c <= `LB_IMG_W - `LB_WIN; c++) begin
                for (int i = 0; i < `LB_WIN; i++) begin
                    for (int j = 0; j < `LB_WIN; j++) begin
                        w[i][j] = img[clamp_index(k - 1 + i)][c + j];
                    end
                end
                exp_q.push_back(w);
            end
        end
    endtask

    task automatic send_frame(input int valid_pct);
        int idx;
        int idle;
        idx  = 0;
        idle = 0;
        while (idx < PIX_N && idle < WAIT_LIMIT) begin
            @(posedge clk);
            idle++;
            if (pix_valid && pix_ready) begin
                idx++;
                idle = 0;
            end
            if (pix_valid && !pix_ready) begin
                pix_valid <= 1'b1;  // hold the offered pixel
            end else if (idx < PIX_N && ($urandom % 100) < valid_pct) begin
                pix_valid <= 1'b1;
                pix_data  <= img[idx / `LB_IMG_W][idx % `LB_IMG_W];
            end else begin
                pix_valid <= 1'b0;
            end
        end
        pix_valid <= 1'b0;
        if (idx < PIX_N) begin
            $display("timeout: pixel %0d of frame %0d was never accepted", idx, frame_no);
            timeout_cnt++;
            abort = 1'b1;
        end
    endtask

    task automatic take_frame(input int ready_pct);
        int widx;
        int idle;
        widx = 0;
        idle = 0;
        while (widx < WIN_N && idle < WAIT_LIMIT) begin
            @(posedge clk);
            idle++;
            if (win_valid && win_ready) begin
                check_val(win_data, exp_q[widx],
                          $sformatf("frame %0d window %0d", frame_no, widx));
                widx++;
                win_checked++;
                idle = 0;
            end
            win_ready <= (($urandom % 100) < ready_pct);
        end
        win_ready <= 1'b0;
        if (widx < WIN_N) begin
            $display("timeout: window %0d of frame %0d never arrived", widx, frame_no);
            timeout_cnt++;
            abort = 1'b1;
        end else begin
            @(posedge clk);
            check_val(frame_done, 1'b1, "frame_done in the cycle after the last window");
        end
    endtask

    // stability under back-pressure, pixel limit and frame_done pulses
    always @(posedge clk) begin
        if (rst_n) begin
            if (stall_q) begin
                check_val(win_valid, 1'b1, "win_valid dropped while stalled");
                check_val(win_data, held_data, "win_data changed while stalled");
            end
            if (pix_cnt == PIX_N) begin
                check_val(pix_ready, 1'b0, "pix_ready high after a full frame");
            end
            if (pix_valid && pix_ready) begin
                pix_cnt = pix_cnt + 1;
            end
            if (win_valid && win_ready) begin
                win_seen = win_seen + 1;
            end
            if (frame_done) begin
                check_val(done_q, 1'b0, "frame_done longer than one cycle");
                check_val(win_seen, WIN_N, "windows accepted before frame_done");
                done_cnt = done_cnt + 1;
                pix_cnt  = 0;
                win_seen = 0;
            end
            stall_q   <= win_valid && !win_ready;
            held_data <= win_data;
            done_q    <= frame_done;
        end
    end

    initial begin
        void'($urandom(32'h375b_6e96));
        rst_n     = 1'b0;
        pix_valid = 1'b0;
        pix_data  = '0;
        win_ready = 1'b0;

        tests[0] = {8'd100, 8'd100, 1'b1};  // full rates
        tests[1] = {8'd100, 8'd100, 1'b0};
        tests[2] = {8'd100, 8'd40,  1'b1};  // output back-pressure
        tests[3] = {8'd35,  8'd100, 1'b0};  // input gaps
        tests[4] = {8'd50,  8'd50,  1'b0};

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_val(win_valid, 1'b0, "win_valid after reset");
        check_val(frame_done, 1'b0, "frame_done after reset");
        check_val(pix_ready, 1'b1, "pix_ready after reset");

        for (int t = 0; t < N_TESTS && !abort; t++) begin
            for (int f = 0; f < 2 && !abort; f++) begin
                fill_image(tests[t].coded);
                build_expected();
                fork
                    send_frame(int'(tests[t].valid_pct));
                    take_frame(int'(tests[t].ready_pct));
                join
                frame_no++;
                frames_run++;
            end
        end

        repeat (2) @(posedge clk);
        if (!abort) begin
            check_val(done_cnt, frames_run, "number of frame_done pulses");
        end

        $display("summary: %0d errors, %0d timeouts, %0d windows checked in %0d frames",
                 error_cnt, timeout_cnt, win_checked, frames_run);
        if (error_cnt == 0 && timeout_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: line_buf_top.f
+incdir+rtl
rtl/line_buf_pkg.sv
rtl/pixel_writer.sv
rtl/line_ram_bank.sv
rtl/window_reader.sv
rtl/line_buf_top.sv
testbench/line_buf_tb.sv
